//--- ahbl_regs.f
ahbl_bus_pkg.sv
ahbl_map_pkg.sv
ahbl_addr_decoder.sv
ahbl_reg_slave.sv
ahbl_resp_mux.sv
ahbl_regs_top.sv
tb_ahbl_regs.sv

//--- ahbl_regs_vectors.txt
# Columns: test name, operation (W write, R read, I idle gap), size (B, H, W),
# address in hex, data in hex (bus write data for W, expected read data for R)
rst_s0_r0      R W 00000000 00000000
rst_s0_r1      R W 01000000 00000000
rst_s0_r2      R W 02000000 00000000
rst_s0_id      R W 03000000 ABCDEF00
rst_s1_r0      R W 10000000 00000000
rst_s1_r1      R W 11000000 00000000
rst_s1_r2      R W 12000000 00000000
rst_s1_id      R W 13000000 ABCDEF01
gap_a          I W 00000000 00000000
# Word writes to every register, then readback
wr_s0_r0       W W 00000000 11223344
wr_s0_r1       W W 01000000 55667788
wr_s0_r2       W W 02000000 99AABBCC
wr_s1_r0       W W 10000000 DEADBEEF
wr_s1_r1       W W 11000000 CAFEF00D
wr_s1_r2       W W 12000000 0BADC0DE
rd_s0_r0       R W 00000000 11223344
rd_s0_r1       R W 01000000 55667788
rd_s0_r2       R W 02000000 99AABBCC
rd_s1_r0       R W 10000000 DEADBEEF
rd_s1_r1       R W 11000000 CAFEF00D
rd_s1_r2       R W 12000000 0BADC0DE
gap_b          I W 00000000 00000000
# Write followed directly by a read of the same register
b2b_wr_s0_r1   W W 01000000 A5A5A5A5
b2b_rd_s0_r1   R W 01000000 A5A5A5A5
b2b_wr_s1_r2   W W 12000000 5A5A5A5A
b2b_rd_s1_r2   R W 12000000 5A5A5A5A
# Byte and halfword writes, the unused lanes carry junk
bw_s0_r0_b1    W B 00000001 FFFFEEFF
bw_rd_s0_r0_b1 R W 00000000 1122EE44
bw_s0_r0_b3    W B 00000003 77FFFFFF
bw_rd_s0_r0_b3 R W 00000000 7722EE44
hw_s0_r0_h2    W H 00000002 ABCD9999
hw_rd_s0_r0_h2 R W 00000000 ABCDEE44
hw_s1_r1_h0    W H 11000000 FFFF1234
hw_rd_s1_r1_h0 R W 11000000 CAFE1234
bw_s1_r1_b2    W B 11000002 00990000
bw_rd_s1_r1_b2 R W 11000000 CA991234
bw_s1_r0_b0    W B 10000000 000000AA
bw_rd_s1_r0_b0 R W 10000000 DEADBEAA
gap_c          I W 00000000 00000000
# Interleaved slave 0 and slave 1 transfers
il_wr_s0_r2    W W 02000000 01020304
il_wr_s1_r0    W W 10000000 0A0B0C0D
il_rd_s0_r2    R W 02000000 01020304
il_rd_s1_r0    R W 10000000 0A0B0C0D
il_rd_s0_r0    R W 00000000 ABCDEE44
il_rd_s1_r1    R W 11000000 CA991234
# Writes that must be dropped
ign_wr_s0_id   W W 03000000 FFFFFFFF
ign_wr_s0_res  W W 04000000 FFFFFFFF
ign_wr_s1_res  W W 17000000 FFFFFFFF
ign_wr_map2    W W 20000000 FFFFFFFF
ign_wr_mapf    W W F0000000 FFFFFFFF
gap_d          I W 00000000 00000000
chk_s0_id      R W 03000000 ABCDEF00
chk_s0_res     R W 04000000 00000000
chk_s1_res     R W 17000000 00000000
chk_map2       R W 20000000 00000000
chk_mapf       R W F1000000 00000000
chk_s0_r0      R W 00000000 ABCDEE44
chk_s0_r1      R W 01000000 A5A5A5A5
chk_s0_r2      R W 02000000 01020304
chk_s1_r0      R W 10000000 0A0B0C0D
chk_s1_r1      R W 11000000 CA991234
chk_s1_r2      R W 12000000 5A5A5A5A
chk_s1_id      R W 13000000 ABCDEF01

//--- tb_ahbl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ahbl_regs
    import ahbl_bus_pkg::*, ahbl_map_pkg::*;
();

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;   // Inputs change this long after the rising edge
    localparam int MAX_VECTORS  = 128;
    localparam int MAX_IDLE_GAP = 3;
    localparam logic [31:0] SEED = 32'h3a665ffb;
    localparam VECTOR_FILE = "ahbl_regs_vectors.txt";

    logic    HCLK;
    logic    HRESETn;
    haddr_t  HADDR;
    htrans_t HTRANS;
    hsize_t  HSIZE;
    logic    HWRITE;
    hdata_t  HWDATA;
    wire     HREADY;
    wire hdata_t HRDATA;

    string   vec_name [MAX_VECTORS];
    string   vec_op   [MAX_VECTORS];
    hsize_t  vec_size [MAX_VECTORS];
    haddr_t  vec_addr [MAX_VECTORS];
    hdata_t  vec_data [MAX_VECTORS];

    int      vec_count;
    bit      loaded;
    int      err_count;
    int      pass_count;
    int      fail_count;
    int      next_idx;
    int      idle_left;
    int      ap_idx;     // Vector in the address phase, -1 for idle
    int      dp_idx;     // Vector in the data phase, -1 for none
    int      dp_waits;

    ahbl_regs_top dut (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .HADDR   (HADDR),
        .HTRANS  (HTRANS),
        .HSIZE   (HSIZE),
        .HWRITE  (HWRITE),
        .HWDATA  (HWDATA),
        .HREADY  (HREADY),
        .HRDATA  (HRDATA)
    );

    initial begin
        HCLK = 1'b0;
    end

    always #(CLK_HALF) HCLK = ~HCLK;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               cnt;
        logic [8*128-1:0] line_v;
        string            name_s;
        string            op_s;
        string            size_s;
        haddr_t           addr_v;
        hdata_t           data_v;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VECTOR_FILE);
            err_count++;
            return;
        end
        while ($fgets(line_v, fd) != 0) begin
            cnt = $sscanf(line_v, "%s %s %s %h %h", name_s, op_s, size_s, addr_v, data_v);
            if (cnt == 5 && name_s.getc(0) != "#") begin
                if (vec_count >= MAX_VECTORS) begin
                    $display("the vector file holds more than %0d lines", MAX_VECTORS);
                    err_count++;
                    break;
                end
                if (op_s != "W" && op_s != "R" && op_s != "I") begin
                    $display("unknown operation %s in vector line %s", op_s, name_s);
                    err_count++;
                end
                vec_name[vec_count] = name_s;
                vec_op[vec_count]   = op_s;
                vec_size[vec_count] = (size_s == "B") ? HSIZE_BYTE :
                                      (size_s == "H") ? HSIZE_HALF : HSIZE_WORD;
                vec_addr[vec_count] = addr_v;
                vec_data[vec_count] = data_v;
                vec_count++;
            end
        end
        $fclose(fd);
    endtask

    // Puts the next address phase on the bus, or an idle cycle
    task automatic present_next();
        HTRANS = HTRANS_IDLE;
        ap_idx = -1;
        if (idle_left > 0) begin
            idle_left--;
        end else if (next_idx < vec_count) begin
            if (vec_op[next_idx] == "I") begin
                idle_left = $urandom % MAX_IDLE_GAP;   // This cycle is the first idle one
            end else begin
                ap_idx = next_idx;
                HADDR  = vec_addr[next_idx];
                HSIZE  = vec_size[next_idx];
                HWRITE = (vec_op[next_idx] == "W");
                HTRANS = HTRANS_NONSEQ;
            end
            next_idx++;
        end
    endtask

    task automatic finish_transfer(input hdata_t rdata);
        int errs_before;
        int exp_waits;
        errs_before = err_count;
        exp_waits   = (vec_addr[dp_idx][31:SLAVE_FIELD_LSB] == 1) ? SLAVE1_WAIT : 0;
        check_value({vec_name[dp_idx], " wait states"}, exp_waits, dp_waits);
        if (vec_op[dp_idx] == "R") begin
            check_value(vec_name[dp_idx], vec_data[dp_idx], rdata);
        end
        if (err_count == errs_before) begin
            pass_count++;
            $display("pass %s", vec_name[dp_idx]);
        end else begin
            fail_count++;
            $display("fail %s", vec_name[dp_idx]);
        end
    endtask

    // Pipelined master, moves on only at edges where HREADY is high
    task automatic run_master();
        logic   ready;
        hdata_t rdata;
        present_next();
        while (ap_idx >= 0 || dp_idx >= 0 || idle_left > 0 || next_idx < vec_count) begin
            @(negedge HCLK);
            ready = HREADY;
            rdata = HRDATA;
            @(posedge HCLK);
            if (!ready) begin
                dp_waits++;   // Address and HWDATA stay as they are
            end else begin
                if (dp_idx >= 0) begin
                    finish_transfer(rdata);
                end
                dp_idx   = ap_idx;
                dp_waits = 0;
                #(DRIVE_DELAY);
                HWDATA = (dp_idx >= 0 && vec_op[dp_idx] == "W") ? vec_data[dp_idx] : '0;
                present_next();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        HRESETn    = 1'b0;
        HADDR      = '0;
        HTRANS     = HTRANS_IDLE;
        HSIZE      = HSIZE_WORD;
        HWRITE     = 1'b0;
        HWDATA     = '0;
        vec_count  = 0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        next_idx   = 0;
        idle_left  = 0;
        ap_idx     = -1;
        dp_idx     = -1;
        dp_waits   = 0;
        load_vectors();
        if (vec_count == 0) begin
            $display("no transfers were loaded from the vector file");
            err_count++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #(DRIVE_DELAY);
        HRESETn = 1'b1;
        run_master();
        repeat (2) @(posedge HCLK);
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Worst case per line is a slave 1 transfer or the longest idle gap
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = vec_count * (2 + SLAVE1_WAIT + MAX_IDLE_GAP) + 100;
        repeat (limit) @(posedge HCLK);
        $display("the run timed out after %0d clock cycles without finishing", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- ahbl_regs_top.sv
`timescale 1ns/100ps
`default_nettype none

module ahbl_regs_top
    import ahbl_bus_pkg::*, ahbl_map_pkg::*;
(
    input  wire        HCLK,
    input  wire        HRESETn,
    input  wire haddr_t  HADDR,
    input  wire htrans_t HTRANS,
    input  wire hsize_t  HSIZE,
    input  wire        HWRITE,
    input  wire hdata_t  HWDATA,
    output wire        HREADY,
    output hdata_t     HRDATA
);

    slave_sel_t hsel;
    slave_sel_t data_sel;
    wire        hreadyout_0;
    wire        hreadyout_1;
    hdata_t     hrdata_0;
    hdata_t     hrdata_1;

    ////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////

    ahbl_addr_decoder u_decoder (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .HREADY   (HREADY),
        .HTRANS   (HTRANS),
        .HADDR    (HADDR),
        .hsel     (hsel),
        .data_sel (data_sel)
    );

    ////////////////////////////////////////////////////////////////////////
    // Register slaves
    ////////////////////////////////////////////////////////////////////////

    ahbl_reg_slave #(
        .ID          (SLAVE0_ID),
        .WAIT_STATES (0)
    ) u_slave0 (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel[0]),
        .HREADY    (HREADY),
        .HTRANS    (HTRANS),
        .HADDR     (HADDR),
        .HSIZE     (HSIZE),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .hreadyout (hreadyout_0),
        .hrdata    (hrdata_0)
    );

    ahbl_reg_slave #(
        .ID          (SLAVE1_ID),
        .WAIT_STATES (SLAVE1_WAIT)
    ) u_slave1 (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel[1]),
        .HREADY    (HREADY),
        .HTRANS    (HTRANS),
        .HADDR     (HADDR),
        .HSIZE     (HSIZE),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .hreadyout (hreadyout_1),
        .hrdata    (hrdata_1)
    );

    ////////////////////////////////////////////////////////////////////////
    // Response back to the master
    ////////////////////////////////////////////////////////////////////////

    ahbl_resp_mux u_resp_mux (
        .data_sel    (data_sel),
        .hreadyout_0 (hreadyout_0),
        .hreadyout_1 (hreadyout_1),
        .hrdata_0    (hrdata_0),
        .hrdata_1    (hrdata_1),
        .HREADY      (HREADY),
        .HRDATA      (HRDATA)
    );

endmodule

`default_nettype wire

//--- ahbl_resp_mux.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Data-phase response multiplexer
////////////////////////////////////////////////////////////////////////////

module ahbl_resp_mux
    import ahbl_bus_pkg::*, ahbl_map_pkg::*;
(
    input  wire slave_sel_t data_sel,
    input  wire        hreadyout_0,
    input  wire        hreadyout_1,
    input  wire hdata_t  hrdata_0,
    input  wire hdata_t  hrdata_1,
    output logic       HREADY,
    output hdata_t     HRDATA
);

    // data_sel is one-hot or zero, so the order of the checks does not matter
    always_comb begin
        if (data_sel[0]) begin
            HREADY = hreadyout_0;
            HRDATA = hrdata_0;
        end else if (data_sel[1]) begin
            HREADY = hreadyout_1;
            HRDATA = hrdata_1;
        end else begin
            // Idle or unmapped transfer gets a zero-wait OKAY with zero data
            HREADY = 1'b1;
            HRDATA = '0;
        end
    end

endmodule

`default_nettype wire

//--- ahbl_reg_slave.sv
`timescale 1ns/100ps
`default_nettype none

module ahbl_reg_slave
    import ahbl_bus_pkg::*, ahbl_map_pkg::*;
#(
    parameter hdata_t ID          = 32'h0,
    parameter int     WAIT_STATES = 0
) (
    input  wire        HCLK,
    input  wire        HRESETn,
    input  wire        hsel,
    input  wire        HREADY,
    input  wire htrans_t HTRANS,
    input  wire haddr_t  HADDR,
    input  wire hsize_t  HSIZE,
    input  wire        HWRITE,
    input  wire hdata_t  HWDATA,
    output logic       hreadyout,
    output hdata_t     hrdata
);

    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic       addr_active;
    byte_en_t   addr_strb;
    reg_off_t   off_q;
    byte_en_t   strb_q;
    logic       write_q;
    logic       active_q;
    logic       wr_en;
    logic [1:0] reg_idx;
    logic [CNT_W-1:0] wait_cnt;
    hdata_t     regs_q [NUM_REGS];

    // Byte lanes touched by a transfer of the given size and alignment
    function automatic byte_en_t lane_strobe(hsize_t size, logic [1:0] addr_lo);
        byte_en_t strb;
        case (size)
            HSIZE_BYTE: strb = byte_en_t'(1) << addr_lo;
            HSIZE_HALF: strb = addr_lo[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: strb = 4'b1111;
            default:    strb = 4'b1111;
        endcase
        return strb;
    endfunction

    assign addr_active = hsel && (HTRANS != HTRANS_IDLE) && (HTRANS != HTRANS_BUSY);
    assign addr_strb   = lane_strobe(HSIZE, HADDR[1:0]);

    ////////////////////////////////////////////////////////////////////////
    // Address phase capture
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            off_q    <= '0;
            strb_q   <= '0;
            write_q  <= 1'b0;
            active_q <= 1'b0;   // Reads as an idle transfer
        end else if (HREADY) begin
            off_q    <= HADDR[REG_OFF_LSB +: $bits(reg_off_t)];
            strb_q   <= addr_strb;
            write_q  <= HWRITE;
            active_q <= addr_active;
        end
    end

    // Wait states at the start of each selected data phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wait_cnt <= '0;
        end else if (HREADY && addr_active) begin
            wait_cnt <= CNT_W'(WAIT_STATES);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign hreadyout = (wait_cnt == '0);

    ////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////

    // Commits on the edge that completes the data phase
    assign wr_en   = active_q && write_q && HREADY;
    assign reg_idx = off_q[1:0];

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wr_en && (off_q < REG_OFF_ID)) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (strb_q[b]) begin
                    regs_q[reg_idx][8*b +: 8] <= HWDATA[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        case (off_q)
            REG_OFF_0:  hrdata = regs_q[0];
            REG_OFF_1:  hrdata = regs_q[1];
            REG_OFF_2:  hrdata = regs_q[2];
            REG_OFF_ID: hrdata = ID;
            default:    hrdata = '0;    // Reserved offsets
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////

    // System HREADY must follow this slave while its data phase is open
    a_no_write_in_wait : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        wr_en |-> hreadyout
    );

    a_half_aligned : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (HREADY && addr_active && HWRITE && (HSIZE == HSIZE_HALF)) |-> !HADDR[0]
    );

endmodule

`default_nettype wire

//--- ahbl_addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module ahbl_addr_decoder
    import ahbl_bus_pkg::*, ahbl_map_pkg::*;
(
    input  wire        HCLK,
    input  wire        HRESETn,
    input  wire        HREADY,
    input  wire htrans_t HTRANS,
    input  wire haddr_t  HADDR,
    output slave_sel_t hsel,
    output slave_sel_t data_sel
);

    logic [SLAVE_FIELD_W-1:0] slave_field;
    logic                     trans_active;

    assign slave_field  = HADDR[31:SLAVE_FIELD_LSB];
    assign trans_active = (HTRANS == HTRANS_NONSEQ) || (HTRANS == HTRANS_SEQ);

    always_comb begin
        hsel = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (slave_field == SLAVE_FIELD_W'(s)) begin
                hsel[s] = 1'b1;
            end
        end
    end

    // Data-phase select follows the accepted address phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            data_sel <= '0;
        end else if (HREADY) begin
            data_sel <= trans_active ? hsel : '0; // Idle cycles fall to the default response
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////

    a_data_sel_onehot : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $onehot0(data_sel)
    );

endmodule

`default_nettype wire

//--- ahbl_map_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Memory map of the register subsystem
////////////////////////////////////////////////////////////////////////////

package ahbl_map_pkg;

    localparam int NUM_SLAVES = 2;

    typedef logic [NUM_SLAVES-1:0] slave_sel_t; // One-hot, all zero when unmapped

    // HADDR[31:28] picks the slave, HADDR[27:24] the register
    localparam int SLAVE_FIELD_LSB = 28;
    localparam int SLAVE_FIELD_W   = 32 - SLAVE_FIELD_LSB;
    localparam int REG_OFF_LSB     = 24;

    typedef logic [3:0] reg_off_t;

    localparam reg_off_t REG_OFF_0  = 4'd0;
    localparam reg_off_t REG_OFF_1  = 4'd1;
    localparam reg_off_t REG_OFF_2  = 4'd2;
    localparam reg_off_t REG_OFF_ID = 4'd3; // Read-only identification word

    localparam int NUM_REGS = 3;

    localparam logic [31:0] SLAVE0_ID = 32'hABCD_EF00;
    localparam logic [31:0] SLAVE1_ID = 32'hABCD_EF01;

    localparam int SLAVE1_WAIT = 1; // Wait states per data phase of slave 1

endpackage

`default_nettype wire

//--- ahbl_bus_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// AHB-Lite signal types and encodings
////////////////////////////////////////////////////////////////////////////

package ahbl_bus_pkg;

    typedef logic [31:0] haddr_t;   // Byte address
    typedef logic [31:0] hdata_t;   // Read and write data
    typedef logic [1:0]  htrans_t;
    typedef logic [2:0]  hsize_t;
    typedef logic [3:0]  byte_en_t; // One bit per byte lane of hdata_t

    // Transfer types
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // Transfer sizes, only the ones a 32-bit bus can carry
    localparam hsize_t HSIZE_BYTE = 3'b000;
    localparam hsize_t HSIZE_HALF = 3'b001;
    localparam hsize_t HSIZE_WORD = 3'b010;

    localparam int BYTE_LANES = 4;

endpackage

`default_nettype wire
